// ==== l1_cache_top.f ====
rtl/l1_cache_pkg.sv
rtl/l1_req_if.sv
rtl/l1_mem_if.sv
rtl/l1_req_capture.sv
rtl/l1_way_store.sv
rtl/l1_cache_ctrl.sv
rtl/l1_mem_port.sv
rtl/l1_cache_top.sv
tests/l1_cache_properties.sv
tests/tb_l1_cache.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_l1_cache -f l1_cache_top.f -o sim_l1_cache
./obj_dir/sim_l1_cache 2>&1 | tee sim.log

if grep -q "All checks passed" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// ==== tests/tb_l1_cache.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_l1_cache import l1_cache_pkg::*; ();

    logic               clk_i;
    logic               rstn_i;
    logic               req_valid_i;
    logic               req_ready_o;
    logic [ADDR_W-1:0]  req_addr_i;
    logic               req_write_i;
    logic [DATA_W-1:0]  req_wdata_i;
    logic               resp_valid_o;
    logic               resp_ready_i;
    logic [DATA_W-1:0]  resp_data_o;
    logic               mem_req_valid_o;
    logic               mem_req_ready_i;
    logic [ADDR_W-1:0]  mem_req_addr_o;
    logic               mem_req_write_o;
    logic [BLOCK_W-1:0] mem_req_wdata_o;
    logic               mem_rdata_valid_i;
    logic               mem_rdata_ready_o;
    logic [BLOCK_W-1:0] mem_rdata_i;

    // Shadow words, main memory blocks and memory traffic counters
    logic [DATA_W-1:0]  shadow   [logic [ADDR_W-1:0]];
    logic [BLOCK_W-1:0] mem_data [logic [ADDR_W-1:0]];
    int unsigned        mem_reqs;
    int unsigned        mem_writes;
    logic [ADDR_W-1:0]  last_mem_addr;
    logic               last_mem_write;
    int unsigned        max_wait = 200;

    enum int {M_IDLE, M_WAIT, M_ACCEPT, M_RDELAY, M_RDATA} mem_state;

    l1_cache_top i_l1_cache_top (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .req_valid_i       (req_valid_i),
        .req_ready_o       (req_ready_o),
        .req_addr_i        (req_addr_i),
        .req_write_i       (req_write_i),
        .req_wdata_i       (req_wdata_i),
        .resp_valid_o      (resp_valid_o),
        .resp_ready_i      (resp_ready_i),
        .resp_data_o       (resp_data_o),
        .mem_req_valid_o   (mem_req_valid_o),
        .mem_req_ready_i   (mem_req_ready_i),
        .mem_req_addr_o    (mem_req_addr_o),
        .mem_req_write_o   (mem_req_write_o),
        .mem_req_wdata_o   (mem_req_wdata_o),
        .mem_rdata_valid_i (mem_rdata_valid_i),
        .mem_rdata_ready_o (mem_rdata_ready_o),
        .mem_rdata_i       (mem_rdata_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [DATA_W-1:0] init_word(input logic [ADDR_W-1:0] addr);
        return addr ^ 32'hA5A5A5A5;
    endfunction

    function automatic logic [ADDR_W-1:0] make_addr(input logic [TAG_W-1:0] tag,
                                                    input logic [INDEX_W-1:0] idx,
                                                    input logic [WORD_SEL_W-1:0] word);
        return {tag, idx, word, 2'b00};
    endfunction

    function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
        return shadow.exists(addr) ? shadow[addr] : init_word(addr);
    endfunction

    function automatic logic [BLOCK_W-1:0] expected_block(input logic [ADDR_W-1:0] blk);
        logic [BLOCK_W-1:0] b;
        for (int i = 0; i < 4; i++) begin
            b[i*DATA_W +: DATA_W] = expected_word(blk + ADDR_W'(4 * i));
        end
        return b;
    endfunction

    // Unwritten memory reads as the address pattern
    function automatic logic [BLOCK_W-1:0] memory_block(input logic [ADDR_W-1:0] blk);
        logic [BLOCK_W-1:0] b;
        for (int i = 0; i < 4; i++) begin
            b[i*DATA_W +: DATA_W] = init_word(blk + ADDR_W'(4 * i));
        end
        return mem_data.exists(blk) ? mem_data[blk] : b;
    endfunction

    task automatic fail_with(input string what);
        $display("Error at %0t ns: %s", $time, what);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        assert (got == exp) else begin
            $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic check_block(input string name, input logic [BLOCK_W-1:0] got,
                               input logic [BLOCK_W-1:0] exp);
        assert (got == exp) else begin
            $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic wait_for_ready(output int lat);
        int n = 0;
        while (!req_ready_o) begin
            next_cycle();
            n++;
            if (n > max_wait) fail_with("timeout waiting for req_ready_o");
        end
        lat = n;
    endtask

    task automatic wait_for_response(output int lat);
        int n = 0;
        while (!resp_valid_o) begin
            next_cycle();
            n++;
            if (n > max_wait) fail_with("timeout waiting for resp_valid_o");
        end
        lat = n;
    endtask

    // Returns just after the accepting edge
    task automatic send_request(input logic [ADDR_W-1:0] addr, input logic write,
                                input logic [DATA_W-1:0] wdata);
        int unused;
        wait_for_ready(unused);
        req_valid_i = 1'b1;
        req_addr_i  = addr;
        req_write_i = write;
        req_wdata_i = wdata;
        next_cycle();
        req_valid_i = 1'b0;
        if (write) shadow[addr] = wdata;
    endtask

    task automatic load_word(input logic [ADDR_W-1:0] addr, output int lat);
        send_request(addr, 1'b0, '0);
        wait_for_response(lat);
        check_word("resp_data_o", resp_data_o, expected_word(addr));
        next_cycle();
    endtask

    task automatic store_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              output int lat);
        send_request(addr, 1'b1, data);
        wait_for_ready(lat);
    endtask

    task automatic held_load(input logic [ADDR_W-1:0] addr, input int hold);
        int lat;
        logic [DATA_W-1:0] held;
        resp_ready_i = 1'b0;
        send_request(addr, 1'b0, '0);
        wait_for_response(lat);
        held = resp_data_o;
        check_word("resp_data_o", held, expected_word(addr));
        repeat (hold) begin
            next_cycle();
            check_word("resp_valid_o", DATA_W'(resp_valid_o), 32'd1);
            check_word("resp_data_o", resp_data_o, held);
            check_word("req_ready_o", DATA_W'(req_ready_o), 32'd0);
        end
        resp_ready_i = 1'b1;
        next_cycle();
    endtask

    // Main memory with random accept and data delays
    initial begin
        int dly;
        logic rdata_taken;
        logic [ADDR_W-1:0] addr;
        logic write;
        logic [BLOCK_W-1:0] wblock;
        mem_req_ready_i   = 1'b0;
        mem_rdata_valid_i = 1'b0;
        mem_rdata_i       = '0;
        mem_state         = M_IDLE;
        mem_reqs          = 0;
        mem_writes        = 0;
        last_mem_addr     = '0;
        last_mem_write    = 1'b0;
        rdata_taken       = 1'b0;
        dly               = 0;
        forever begin
            next_cycle();
            if (!rstn_i) begin
                mem_state         = M_IDLE;
                mem_req_ready_i   = 1'b0;
                mem_rdata_valid_i = 1'b0;
            end else begin
                case (mem_state)
                    M_IDLE: begin
                        if (mem_req_valid_o) begin
                            addr   = mem_req_addr_o;
                            write  = mem_req_write_o;
                            wblock = mem_req_wdata_o;
                            dly    = $urandom_range(0, 3);
                            if (dly == 0) begin
                                mem_req_ready_i = 1'b1;
                                mem_state       = M_ACCEPT;
                            end else begin
                                mem_state = M_WAIT;
                            end
                        end
                    end
                    M_WAIT: begin
                        dly--;
                        if (dly == 0) begin
                            mem_req_ready_i = 1'b1;
                            mem_state       = M_ACCEPT;
                        end
                    end
                    M_ACCEPT: begin
                        mem_req_ready_i = 1'b0;
                        mem_reqs++;
                        last_mem_addr  = addr;
                        last_mem_write = write;
                        check_word("mem_req_addr_o offset", DATA_W'(addr[3:0]), 32'd0);
                        if (write) begin
                            check_block("mem_req_wdata_o", wblock, expected_block(addr));
                            mem_data[addr] = wblock;
                            mem_writes++;
                            mem_state = M_IDLE;
                        end else begin
                            dly       = $urandom_range(1, 4);
                            mem_state = M_RDELAY;
                        end
                    end
                    M_RDELAY: begin
                        dly--;
                        if (dly == 0) begin
                            mem_rdata_valid_i = 1'b1;
                            mem_rdata_i       = memory_block(addr);
                            mem_state         = M_RDATA;
                        end
                    end
                    M_RDATA: begin
                        if (rdata_taken) begin
                            mem_rdata_valid_i = 1'b0;
                            mem_state         = M_IDLE;
                        end else begin
                            dly++;
                            if (dly > max_wait) begin
                                fail_with("timeout waiting for mem_rdata_ready_o");
                            end
                        end
                    end
                    default: mem_state = M_IDLE;
                endcase
                rdata_taken = mem_rdata_valid_i && mem_rdata_ready_o;
            end
        end
    end

    initial begin
        int lat;
        int unsigned reqs_before;
        int unsigned writes_before;
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] b;
        logic [ADDR_W-1:0] c;
        void'($urandom(32'h5831));
        rstn_i       = 1'b0;
        req_valid_i  = 1'b0;
        req_addr_i   = '0;
        req_write_i  = 1'b0;
        req_wdata_i  = '0;
        resp_ready_i = 1'b1;
        repeat (3) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        check_word("req_ready_o", DATA_W'(req_ready_o), 32'd1);
        check_word("resp_valid_o", DATA_W'(resp_valid_o), 32'd0);
        check_word("mem_req_valid_o", DATA_W'(mem_req_valid_o), 32'd0);
        check_word("mem_rdata_ready_o", DATA_W'(mem_rdata_ready_o), 32'd0);

        // Read miss, then a hit in the same block
        a = make_addr(24'h000123, 4'd1, 2'd2);
        reqs_before = mem_reqs;
        load_word(a, lat);
        check_word("memory request count", mem_reqs, reqs_before + 1);
        check_word("mem_req_addr_o", last_mem_addr, {a[ADDR_W-1:OFFSET_W], 4'h0});
        check_word("mem_req_write_o", DATA_W'(last_mem_write), 32'd0);
        reqs_before = mem_reqs;
        load_word(make_addr(24'h000123, 4'd1, 2'd0), lat);
        check_word("read hit latency", lat, 32'd2);
        check_word("memory request count", mem_reqs, reqs_before);

        // Write miss, then a write hit
        b = make_addr(24'h000456, 4'd2, 2'd1);
        store_word(b, 32'hCAFE0001, lat);
        load_word(b, lat);
        reqs_before = mem_reqs;
        store_word(make_addr(24'h000456, 4'd2, 2'd3), 32'h1234ABCD, lat);
        check_word("write hit latency", lat, 32'd2);
        check_word("memory request count", mem_reqs, reqs_before);
        load_word(make_addr(24'h000456, 4'd2, 2'd3), lat);
        load_word(b, lat);

        // Both ways of set 5 dirty, a third tag forces a write-back
        a = make_addr(24'h0A0001, 4'd5, 2'd0);
        b = make_addr(24'h0B0002, 4'd5, 2'd1);
        c = make_addr(24'h0C0003, 4'd5, 2'd2);
        store_word(a, 32'h600DF00D, lat);
        store_word(b, 32'hDEAD0B0B, lat);
        writes_before = mem_writes;
        load_word(c, lat);
        check_word("memory write count", mem_writes, writes_before + 1);
        load_word(a, lat);
        load_word(b, lat);
        load_word(c, lat);

        held_load(make_addr(24'h000123, 4'd1, 2'd2), 5);

        for (int i = 0; i < 80; i++) begin
            a = make_addr(TAG_W'(24'h000100 + $urandom_range(0, 3)),
                          INDEX_W'(8 + $urandom_range(0, 2)),
                          WORD_SEL_W'($urandom_range(0, 3)));
            if ($urandom_range(0, 1) == 1) begin
                store_word(a, $urandom(), lat);
            end else begin
                load_word(a, lat);
            end
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/l1_cache_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module l1_cache_properties import l1_cache_pkg::*; (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               req_ready_o,
    input  logic               resp_valid_o,
    input  logic               resp_ready_i,
    input  logic [DATA_W-1:0]  resp_data_o,
    input  logic               mem_req_valid_o,
    input  logic               mem_req_ready_i,
    input  logic [ADDR_W-1:0]  mem_req_addr_o,
    input  logic               mem_req_write_o,
    input  logic [BLOCK_W-1:0] mem_req_wdata_o
);

    // Load response holds until it is taken
    resp_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_data_o))
        else $error("load response changed while resp_ready_i was low");

    mem_req_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o
            && $stable(mem_req_addr_o) && $stable(mem_req_write_o)
            && $stable(mem_req_wdata_o))
        else $error("memory request changed while mem_req_ready_i was low");

    // Nothing else moves while a response is pending
    no_mem_during_resp: assert property (@(posedge clk_i) disable iff (!rstn_i)
        resp_valid_o |-> !mem_req_valid_o)
        else $error("memory request raised during a pending load response");

    no_accept_during_resp: assert property (@(posedge clk_i) disable iff (!rstn_i)
        resp_valid_o |-> !req_ready_o)
        else $error("request channel ready during a pending load response");

endmodule

bind l1_cache_top l1_cache_properties i_l1_cache_properties (
    .clk_i           (clk_i),
    .rstn_i          (rstn_i),
    .req_ready_o     (req_ready_o),
    .resp_valid_o    (resp_valid_o),
    .resp_ready_i    (resp_ready_i),
    .resp_data_o     (resp_data_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_write_o (mem_req_write_o),
    .mem_req_wdata_o (mem_req_wdata_o)
);

`default_nettype wire

// ==== rtl/l1_cache_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module l1_cache_top import l1_cache_pkg::*; (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               req_valid_i,
    output logic               req_ready_o,
    input  logic [ADDR_W-1:0]  req_addr_i,
    input  logic               req_write_i,
    input  logic [DATA_W-1:0]  req_wdata_i,
    output logic               resp_valid_o,
    input  logic               resp_ready_i,
    output logic [DATA_W-1:0]  resp_data_o,
    output logic               mem_req_valid_o,
    input  logic               mem_req_ready_i,
    output logic [ADDR_W-1:0]  mem_req_addr_o,
    output logic               mem_req_write_o,
    output logic [BLOCK_W-1:0] mem_req_wdata_o,
    input  logic               mem_rdata_valid_i,
    output logic               mem_rdata_ready_o,
    input  logic [BLOCK_W-1:0] mem_rdata_i
);

    l1_req_if req_bus ();
    l1_mem_if mem_bus ();

    logic               fill;
    logic [BLOCK_W-1:0] fill_block;
    logic [WAY_W-1:0]   fill_way;
    logic               store;
    logic [WAY_W-1:0]   store_way;
    logic [DATA_W-1:0]  store_data;
    logic               hit;
    logic [WAY_W-1:0]   hit_way;
    logic [DATA_W-1:0]  hit_word;
    logic [WAY_W-1:0]   victim_way;
    logic               victim_dirty;
    l1_addr_u           victim_addr;
    logic [BLOCK_W-1:0] victim_block;

    l1_req_capture i_l1_req_capture (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_valid_i (req_valid_i),
        .req_addr_i  (req_addr_i),
        .req_write_i (req_write_i),
        .req_wdata_i (req_wdata_i),
        .req_ready_o (req_ready_o),
        .req         (req_bus.cap)
    );

    l1_way_store i_l1_way_store (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .lookup_addr_i  (req_bus.addr),
        .fill_i         (fill),
        .fill_block_i   (fill_block),
        .fill_way_i     (fill_way),
        .store_i        (store),
        .store_way_i    (store_way),
        .store_data_i   (store_data),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .hit_word_o     (hit_word),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_addr_o  (victim_addr),
        .victim_block_o (victim_block)
    );

    l1_cache_ctrl i_l1_cache_ctrl (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .resp_ready_i   (resp_ready_i),
        .resp_valid_o   (resp_valid_o),
        .resp_data_o    (resp_data_o),
        .req            (req_bus.ctrl),
        .mem            (mem_bus.ctrl),
        .fill_o         (fill),
        .fill_block_o   (fill_block),
        .fill_way_o     (fill_way),
        .store_o        (store),
        .store_way_o    (store_way),
        .store_data_o   (store_data),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .hit_word_i     (hit_word),
        .victim_way_i   (victim_way),
        .victim_dirty_i (victim_dirty),
        .victim_addr_i  (victim_addr),
        .victim_block_i (victim_block)
    );

    l1_mem_port i_l1_mem_port (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .mem_req_ready_i   (mem_req_ready_i),
        .mem_rdata_valid_i (mem_rdata_valid_i),
        .mem_rdata_i       (mem_rdata_i),
        .mem_req_valid_o   (mem_req_valid_o),
        .mem_req_addr_o    (mem_req_addr_o),
        .mem_req_write_o   (mem_req_write_o),
        .mem_req_wdata_o   (mem_req_wdata_o),
        .mem_rdata_ready_o (mem_rdata_ready_o),
        .mem               (mem_bus.port)
    );

endmodule

`default_nettype wire

// ==== rtl/l1_mem_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module l1_mem_port import l1_cache_pkg::*; (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               mem_req_ready_i,
    input  logic               mem_rdata_valid_i,
    input  logic [BLOCK_W-1:0] mem_rdata_i,
    output logic               mem_req_valid_o,
    output logic [ADDR_W-1:0]  mem_req_addr_o,
    output logic               mem_req_write_o,
    output logic [BLOCK_W-1:0] mem_req_wdata_o,
    output logic               mem_rdata_ready_o,
    l1_mem_if.port             mem
);

    logic               req_valid_q;
    logic               rdata_ready_q;
    logic               rdone_q;
    l1_addr_u           addr_q;
    logic               write_q;
    logic [BLOCK_W-1:0] wdata_q;
    logic [BLOCK_W-1:0] rblock_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            req_valid_q   <= 1'b0;
            rdata_ready_q <= 1'b0;
            rdone_q       <= 1'b0;
        end else begin
            rdone_q <= 1'b0;
            if (mem.start) begin
                req_valid_q <= 1'b1;
            end else if (req_valid_q && mem_req_ready_i) begin
                req_valid_q   <= 1'b0;
                // Reads wait for their block
                rdata_ready_q <= !write_q;
            end else if (rdata_ready_q && mem_rdata_valid_i) begin
                rdata_ready_q <= 1'b0;
                rdone_q       <= 1'b1;
            end
        end
    end

    // Request payload holds from start until accepted
    always_ff @(posedge clk_i) begin
        if (mem.start) begin
            addr_q.f.tag      <= mem.addr.f.tag;
            addr_q.f.index    <= mem.addr.f.index;
            addr_q.f.word     <= '0;
            addr_q.f.byte_sel <= '0;
            write_q           <= mem.write;
            wdata_q           <= mem.wblock;
        end
        if (rdata_ready_q && mem_rdata_valid_i) begin
            rblock_q <= mem_rdata_i;
        end
    end

    assign mem_req_valid_o   = req_valid_q;
    assign mem_req_addr_o    = addr_q.flat;
    assign mem_req_write_o   = write_q;
    assign mem_req_wdata_o   = wdata_q;
    assign mem_rdata_ready_o = rdata_ready_q;

    assign mem.busy   = req_valid_q || rdata_ready_q;
    assign mem.rblock = rblock_q;
    assign mem.rdone  = rdone_q;

endmodule

`default_nettype wire

// ==== rtl/l1_cache_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module l1_cache_ctrl import l1_cache_pkg::*; (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               resp_ready_i,
    output logic               resp_valid_o,
    output logic [DATA_W-1:0]  resp_data_o,
    l1_req_if.ctrl             req,
    l1_mem_if.ctrl             mem,
    output logic               fill_o,
    output logic [BLOCK_W-1:0] fill_block_o,
    output logic [WAY_W-1:0]   fill_way_o,
    output logic               store_o,
    output logic [WAY_W-1:0]   store_way_o,
    output logic [DATA_W-1:0]  store_data_o,
    input  logic               hit_i,
    input  logic [WAY_W-1:0]   hit_way_i,
    input  logic [DATA_W-1:0]  hit_word_i,
    input  logic [WAY_W-1:0]   victim_way_i,
    input  logic               victim_dirty_i,
    input  l1_addr_u           victim_addr_i,
    input  logic [BLOCK_W-1:0] victim_block_i
);

    l1_state_e         state_q;
    l1_state_e         state_d;
    logic [WAY_W-1:0]  victim_q;
    logic              resp_valid_q;
    logic [DATA_W-1:0] resp_data_q;
    logic              load_hit;

    assign load_hit = (state_q == ST_LOOKUP) && hit_i && !req.write;

    always_comb begin
        state_d   = state_q;
        req.done  = 1'b0;
        store_o   = 1'b0;
        fill_o    = 1'b0;
        mem.start = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (req.valid) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (hit_i && req.write) begin
                    store_o  = 1'b1;
                    req.done = 1'b1;
                    state_d  = ST_IDLE;
                end else if (hit_i) begin
                    state_d = ST_RESPOND;
                end else if (victim_dirty_i) begin
                    // Dirty victim goes out first
                    mem.start = 1'b1;
                    state_d   = ST_WRITEBACK;
                end else begin
                    state_d = ST_REFILL_REQ;
                end
            end
            ST_RESPOND: begin
                if (resp_ready_i) begin
                    req.done = 1'b1;
                    state_d  = ST_IDLE;
                end
            end
            ST_WRITEBACK: begin
                if (!mem.busy) begin
                    state_d = ST_REFILL_REQ;
                end
            end
            ST_REFILL_REQ: begin
                mem.start = 1'b1;
                state_d   = ST_REFILL_WAIT;
            end
            ST_REFILL_WAIT: begin
                // Retry the lookup once the block is in
                if (mem.rdone) begin
                    fill_o  = 1'b1;
                    state_d = ST_LOOKUP;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    // Write-back only ever starts from lookup
    assign mem.write     = (state_q == ST_LOOKUP);
    assign mem.addr.flat = mem.write ? victim_addr_i.flat : req.addr.flat;
    assign mem.wblock    = victim_block_i;

    assign fill_block_o = mem.rblock;
    assign fill_way_o   = victim_q;
    assign store_way_o  = hit_way_i;
    assign store_data_o = req.wdata;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q      <= ST_IDLE;
            resp_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (load_hit) begin
                resp_valid_q <= 1'b1;
            end else if (resp_ready_i) begin
                resp_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_LOOKUP) begin
            victim_q <= victim_way_i;
        end
        if (load_hit) begin
            resp_data_q <= hit_word_i;
        end
    end

    assign resp_valid_o = resp_valid_q;
    assign resp_data_o  = resp_data_q;

endmodule

`default_nettype wire

// ==== rtl/l1_way_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module l1_way_store import l1_cache_pkg::*; (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  l1_addr_u           lookup_addr_i,
    input  logic               fill_i,
    input  logic [BLOCK_W-1:0] fill_block_i,
    input  logic [WAY_W-1:0]   fill_way_i,
    input  logic               store_i,
    input  logic [WAY_W-1:0]   store_way_i,
    input  logic [DATA_W-1:0]  store_data_i,
    output logic               hit_o,
    output logic [WAY_W-1:0]   hit_way_o,
    output logic [DATA_W-1:0]  hit_word_o,
    output logic [WAY_W-1:0]   victim_way_o,
    output logic               victim_dirty_o,
    output l1_addr_u           victim_addr_o,
    output logic [BLOCK_W-1:0] victim_block_o
);

    logic [TAG_W-1:0]   tag_q   [SETS][WAYS];
    logic [BLOCK_W-1:0] block_q [SETS][WAYS];
    logic [WAYS-1:0]    valid_q [SETS];
    logic [WAYS-1:0]    dirty_q [SETS];
    logic [WAY_W-1:0]   rr_ptr_q;
    logic [INDEX_W-1:0] idx;

    assign idx = lookup_addr_i.f.index;

    // Tag compare across the ways of the addressed set
    always_comb begin
        hit_o     = 1'b0;
        hit_way_o = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (valid_q[idx][w] && tag_q[idx][w] == lookup_addr_i.f.tag) begin
                hit_o     = 1'b1;
                hit_way_o = WAY_W'(w);
            end
        end
    end

    assign hit_word_o = block_q[idx][hit_way_o][lookup_addr_i.f.word * DATA_W +: DATA_W];

    // Lowest invalid way wins, otherwise the rotating pointer
    always_comb begin
        victim_way_o = rr_ptr_q;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!valid_q[idx][w]) begin
                victim_way_o = WAY_W'(w);
            end
        end
    end

    assign victim_dirty_o = valid_q[idx][victim_way_o] && dirty_q[idx][victim_way_o];
    assign victim_block_o = block_q[idx][victim_way_o];

    always_comb begin
        victim_addr_o.f.tag      = tag_q[idx][victim_way_o];
        victim_addr_o.f.index    = idx;
        victim_addr_o.f.word     = '0;
        victim_addr_o.f.byte_sel = '0;
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tag_q[idx][fill_way_i]   <= lookup_addr_i.f.tag;
            block_q[idx][fill_way_i] <= fill_block_i;
        end else if (store_i) begin
            block_q[idx][store_way_i][lookup_addr_i.f.word * DATA_W +: DATA_W] <= store_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            rr_ptr_q <= '0;
        end else if (fill_i) begin
            // Fresh block is clean
            valid_q[idx][fill_way_i] <= 1'b1;
            dirty_q[idx][fill_way_i] <= 1'b0;
            rr_ptr_q                 <= rr_ptr_q + 1'b1;
        end else if (store_i) begin
            dirty_q[idx][store_way_i] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/l1_req_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

module l1_req_capture import l1_cache_pkg::*; (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              req_valid_i,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic              req_write_i,
    input  logic [DATA_W-1:0] req_wdata_i,
    output logic              req_ready_o,
    l1_req_if.cap             req
);

    logic              ready_q;
    logic              valid_q;
    l1_addr_u          addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic              write_q;
    logic              accept;

    assign accept = req_valid_i && ready_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            ready_q <= 1'b1;
            valid_q <= 1'b0;
        end else if (accept) begin
            ready_q <= 1'b0;
            valid_q <= 1'b1;
        end else if (req.done) begin
            ready_q <= 1'b1;
            valid_q <= 1'b0;
        end
    end

    // Payload only changes on the accepting edge
    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q.flat <= req_addr_i;
            wdata_q     <= req_wdata_i;
            write_q     <= req_write_i;
        end
    end

    assign req_ready_o = ready_q;
    assign req.valid   = valid_q;
    assign req.addr    = addr_q;
    assign req.wdata   = wdata_q;
    assign req.write   = write_q;

endmodule

`default_nettype wire

// ==== rtl/l1_mem_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface l1_mem_if import l1_cache_pkg::*;
();

    // Controller side, start is a single-cycle pulse
    logic               start;
    logic               write;
    l1_addr_u           addr;
    logic [BLOCK_W-1:0] wblock;

    // Port side
    logic               busy;
    logic [BLOCK_W-1:0] rblock;
    logic               rdone;

    modport ctrl (
        output start, write, addr, wblock,
        input  busy, rblock, rdone
    );

    modport port (
        input  start, write, addr, wblock,
        output busy, rblock, rdone
    );

endinterface

`default_nettype wire

// ==== rtl/l1_req_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// Captured request, held until the controller finishes it
interface l1_req_if import l1_cache_pkg::*;
();

    logic              valid;
    l1_addr_u          addr;
    logic [DATA_W-1:0] wdata;
    logic              write;
    logic              done;

    modport cap (output valid, addr, wdata, write, input done);
    modport ctrl (input valid, addr, wdata, write, output done);

endinterface

`default_nettype wire

// ==== rtl/l1_cache_pkg.sv ====
`default_nettype none

package l1_cache_pkg;

    // Cache geometry
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int BLOCK_W    = 128;
    localparam int WAYS       = 2;
    localparam int SETS       = 16;
    localparam int OFFSET_W   = 4;
    localparam int INDEX_W    = 4;
    localparam int TAG_W      = 24;
    localparam int WORD_SEL_W = 2;
    localparam int WAY_W      = 1;

    // One address word, seen flat or split into its fields
    typedef union packed {
        logic [ADDR_W-1:0] flat;
        struct packed {
            logic [TAG_W-1:0]               tag;
            logic [INDEX_W-1:0]             index;
            logic [WORD_SEL_W-1:0]          word;
            logic [OFFSET_W-WORD_SEL_W-1:0] byte_sel;
        } f;
    } l1_addr_u;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_RESPOND,
        ST_WRITEBACK,
        ST_REFILL_REQ,
        ST_REFILL_WAIT
    } l1_state_e;

endpackage

`default_nettype wire
